//--- design/mem_params.svh
// word, register address, byte lane and opcode width defines

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// data and address width
`define MEM_XLEN 32

// register file address width
`define MEM_REG_AW 5

// byte lanes in one data word
`define MEM_LANES 4

// memory opcode width
`define MEM_OP_W 4

`endif

//--- design/mem_op_pkg.sv
// memory opcode enum and architectural exception code enum
`default_nettype none

`include "mem_params.svh"

package mem_op_pkg;

  // operations seen by the memory stage
  typedef enum logic [`MEM_OP_W-1:0] {
    MEM_NOP,
    MEM_LB,
    MEM_LBU,
    MEM_LH,
    MEM_LHU,
    MEM_LW,
    MEM_SB,
    MEM_SH,
    MEM_SW,
    MEM_LL,
    MEM_SC
  } mem_op_e;

  // values follow the MIPS Cause.ExcCode field
  typedef enum logic [4:0] {
    EXC_NONE    = 5'd0,
    EXC_SYSCALL = 5'd8,
    EXC_RI      = 5'd10,
    EXC_OV      = 5'd12,
    EXC_TRAP    = 5'd13,
    EXC_ERET    = 5'd14
  } exc_code_e;

endpackage

`default_nettype wire

//--- design/mem_bus_pkg.sv
// packed structs passed between execute, memory stage, data memory and writeback
`default_nettype none

`include "mem_params.svh"

package mem_bus_pkg;

  // one instruction handed over by execute
  typedef struct packed {
    mem_op_pkg::mem_op_e      op;
    logic [`MEM_XLEN-1:0]     addr;
    logic [`MEM_XLEN-1:0]     store_data;
    logic [`MEM_REG_AW-1:0]   wd;
    logic                     wreg;
    logic [`MEM_XLEN-1:0]     alu_result;
  } ex_mem_t;

  // raw exception flags from execute
  typedef struct packed {
    logic syscall;
    logic inst_invalid;
    logic trap;
    logic overflow;
    logic eret;
  } exc_flags_t;

  // data memory request, lanes big-endian
  typedef struct packed {
    logic                   ce;
    logic                   we;
    logic [`MEM_LANES-1:0]  sel;
    logic [`MEM_XLEN-1:0]   addr;
    logic [`MEM_XLEN-1:0]   wdata;
  } mem_req_t;

  // link bit write
  typedef struct packed {
    logic we;
    logic value;
  } ll_upd_t;

  // register file write from writeback
  typedef struct packed {
    logic                     wreg;
    logic [`MEM_REG_AW-1:0]   wd;
    logic [`MEM_XLEN-1:0]     wdata;
  } wb_t;

endpackage

`default_nettype wire

//--- design/except_resolve.sv
// fixed priority encoder from execute exception flags to one exception code
`default_nettype none

module except_resolve (
  input  mem_bus_pkg::exc_flags_t exc_i,
  output mem_op_pkg::exc_code_e   exc_code_o
);

  import mem_op_pkg::*;

  // first flag set wins
  always_comb
  begin
    if (exc_i.syscall)
    begin
      exc_code_o = EXC_SYSCALL;
    end
    else if (exc_i.inst_invalid)
    begin
      exc_code_o = EXC_RI;
    end
    else if (exc_i.trap)
    begin
      exc_code_o = EXC_TRAP;
    end
    else if (exc_i.overflow)
    begin
      exc_code_o = EXC_OV;
    end
    else if (exc_i.eret)
    begin
      exc_code_o = EXC_ERET;
    end
    else
    begin
      exc_code_o = EXC_NONE;
    end
  end

endmodule

`default_nettype wire

//--- design/lsu_request.sv
// data memory request decode, stall request, SC success and link bit update
`default_nettype none

`include "mem_params.svh"

module lsu_request (
  input  mem_bus_pkg::ex_mem_t    ex_i,
  input  mem_op_pkg::exc_code_e   exc_code_i,
  input  logic                    ll_bit_i,
  input  logic                    mem_rdata_valid_i,
  input  logic                    mem_wresp_valid_i,
  output mem_bus_pkg::mem_req_t   mem_req_o,
  output logic                    stall_o,
  output logic                    sc_ok_o,
  output mem_bus_pkg::ll_upd_t    ll_upd_o,
  output logic                    wreg_o
);

  import mem_op_pkg::*;
  import mem_bus_pkg::*;

  localparam int unsigned lane_aw = $clog2(`MEM_LANES);

  logic [lane_aw-1:0]     off;
  logic [`MEM_LANES-1:0]  byte_sel;
  logic [`MEM_LANES-1:0]  half_sel;
  logic                   exc_hit;
  logic                   sc_go;
  mem_req_t               req;

  assign off      = ex_i.addr[lane_aw-1:0];
  // offset 0 is the most significant lane
  assign byte_sel = {1'b1, {(`MEM_LANES-1){1'b0}}} >> off;
  assign half_sel = off[0] ? '0 : ({2'b11, {(`MEM_LANES-2){1'b0}}} >> off);
  assign exc_hit  = (exc_code_i != EXC_NONE);
  assign sc_go    = (ex_i.op == MEM_SC) && ll_bit_i;

  always_comb
  begin
    req = '0;
    case (ex_i.op)
      MEM_LB, MEM_LBU:
      begin
        req.ce  = 1'b1;
        req.sel = byte_sel;
      end
      MEM_LH, MEM_LHU:
      begin
        req.ce  = 1'b1;
        req.sel = half_sel;
      end
      MEM_LW, MEM_LL:
      begin
        req.ce  = 1'b1;
        req.sel = '1;
      end
      MEM_SB:
      begin
        req.ce    = 1'b1;
        req.we    = 1'b1;
        req.sel   = byte_sel;
        req.wdata = {`MEM_LANES{ex_i.store_data[7:0]}};
      end
      MEM_SH:
      begin
        req.ce    = 1'b1;
        req.we    = 1'b1;
        req.sel   = half_sel;
        req.wdata = {(`MEM_LANES/2){ex_i.store_data[15:0]}};
      end
      MEM_SW:
      begin
        req.ce    = 1'b1;
        req.we    = 1'b1;
        req.sel   = '1;
        req.wdata = ex_i.store_data;
      end
      MEM_SC:
      begin
        // store only with the link still held
        req.ce    = ll_bit_i;
        req.we    = ll_bit_i;
        req.sel   = ll_bit_i ? '1 : '0;
        req.wdata = ll_bit_i ? ex_i.store_data : '0;
      end
      default:
      begin
        req = '0;
      end
    endcase
    if (req.ce)
    begin
      req.addr = ex_i.addr;
    end
  end

  // exception cancels the access
  always_comb
  begin
    mem_req_o = req;
    if (exc_hit)
    begin
      mem_req_o.ce = 1'b0;
      mem_req_o.we = 1'b0;
    end
  end

  assign stall_o = mem_req_o.ce && (mem_req_o.we ? !mem_wresp_valid_i : !mem_rdata_valid_i);
  assign sc_ok_o = sc_go && !exc_hit;
  assign wreg_o  = ex_i.wreg && !exc_hit;

  always_comb
  begin
    ll_upd_o = '0;
    if (exc_hit)
    begin
      ll_upd_o.we = 1'b1;
    end
    else if (ex_i.op == MEM_LL)
    begin
      ll_upd_o.we    = 1'b1;
      ll_upd_o.value = 1'b1;
    end
    else if (sc_go)
    begin
      ll_upd_o.we = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/load_formatter.sv
// load lane selection with sign or zero extension, SC result and ALU result pass
`default_nettype none

`include "mem_params.svh"

module load_formatter (
  input  mem_bus_pkg::ex_mem_t  ex_i,
  input  logic [`MEM_XLEN-1:0]  mem_rdata_i,
  input  logic                  sc_ok_i,
  output logic [`MEM_XLEN-1:0]  wdata_o
);

  import mem_op_pkg::*;

  localparam int unsigned lane_aw = $clog2(`MEM_LANES);

  logic [lane_aw-1:0]  off;
  logic [7:0]          byte_lane;
  logic [15:0]         half_lane;
  logic                half_ok;

  assign off       = ex_i.addr[lane_aw-1:0];
  // big-endian lanes, offset 0 is bits 31..24
  assign byte_lane = mem_rdata_i[8*(`MEM_LANES-1-off) +: 8];
  assign half_lane = off[1] ? mem_rdata_i[`MEM_XLEN/2-1:0]
                            : mem_rdata_i[`MEM_XLEN-1:`MEM_XLEN/2];
  assign half_ok   = !off[0];

  always_comb
  begin
    wdata_o = ex_i.alu_result;
    case (ex_i.op)
      MEM_LB:
      begin
        wdata_o = {{(`MEM_XLEN-8){byte_lane[7]}}, byte_lane};
      end
      MEM_LBU:
      begin
        wdata_o = {{(`MEM_XLEN-8){1'b0}}, byte_lane};
      end
      MEM_LH:
      begin
        wdata_o = half_ok ? {{(`MEM_XLEN-16){half_lane[15]}}, half_lane} : '0;
      end
      MEM_LHU:
      begin
        wdata_o = half_ok ? {{(`MEM_XLEN-16){1'b0}}, half_lane} : '0;
      end
      MEM_LW, MEM_LL:
      begin
        wdata_o = mem_rdata_i;
      end
      MEM_SC:
      begin
        wdata_o = {{(`MEM_XLEN-1){1'b0}}, sc_ok_i};
      end
      default:
      begin
        wdata_o = ex_i.alu_result;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/mem_wb_reg.sv
// memory to writeback pipeline register and LL/SC link bit register
`default_nettype none

`include "mem_params.svh"

module mem_wb_reg (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    stall_i,
  input  logic [`MEM_REG_AW-1:0]  wd_i,
  input  logic                    wreg_i,
  input  logic [`MEM_XLEN-1:0]    wdata_i,
  input  mem_bus_pkg::ll_upd_t    ll_upd_i,
  output logic                    ll_bit_o,
  output mem_bus_pkg::wb_t        wb_o
);

  import mem_bus_pkg::*;

  wb_t   wb_d;
  logic  ll_load;

  // stalled cycle retires nothing
  always_comb
  begin
    wb_d.wreg  = wreg_i && !stall_i;
    wb_d.wd    = wd_i;
    wb_d.wdata = wdata_i;
  end

  // link bit moves only when the instruction retires
  assign ll_load = ll_upd_i.we && !stall_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      wb_o     <= '0;
      ll_bit_o <= 1'b0;
    end
    else
    begin
      wb_o <= wb_d;
      if (ll_load)
      begin
        ll_bit_o <= ll_upd_i.value;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/mem_stage_top.sv
// memory stage top with exception resolve, request decode, load format and writeback register
`default_nettype none

`include "mem_params.svh"

module mem_stage_top (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  mem_bus_pkg::ex_mem_t     ex_i,
  input  mem_bus_pkg::exc_flags_t  exc_i,
  input  logic [`MEM_XLEN-1:0]     mem_rdata_i,
  input  logic                     mem_rdata_valid_i,
  input  logic                     mem_wresp_valid_i,
  output mem_bus_pkg::mem_req_t    mem_req_o,
  output logic                     stall_o,
  output mem_op_pkg::exc_code_e    exc_code_o,
  output mem_bus_pkg::wb_t         wb_o
);

  import mem_bus_pkg::*;

  logic                  sc_ok;
  logic                  wreg;
  logic                  ll_bit;
  logic [`MEM_XLEN-1:0]  wdata;
  ll_upd_t               ll_upd;

  except_resolve i_except_resolve (
    .exc_i      (exc_i),
    .exc_code_o (exc_code_o)
  );

  lsu_request i_lsu_request (
    .ex_i              (ex_i),
    .exc_code_i        (exc_code_o),
    .ll_bit_i          (ll_bit),
    .mem_rdata_valid_i (mem_rdata_valid_i),
    .mem_wresp_valid_i (mem_wresp_valid_i),
    .mem_req_o         (mem_req_o),
    .stall_o           (stall_o),
    .sc_ok_o           (sc_ok),
    .ll_upd_o          (ll_upd),
    .wreg_o            (wreg)
  );

  load_formatter i_load_formatter (
    .ex_i        (ex_i),
    .mem_rdata_i (mem_rdata_i),
    .sc_ok_i     (sc_ok),
    .wdata_o     (wdata)
  );

  mem_wb_reg i_mem_wb_reg (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .stall_i  (stall_o),
    .wd_i     (ex_i.wd),
    .wreg_i   (wreg),
    .wdata_i  (wdata),
    .ll_upd_i (ll_upd),
    .ll_bit_o (ll_bit),
    .wb_o     (wb_o)
  );

endmodule

`default_nettype wire

//--- test/mem_stage_checker.sv
// checker comparing memory stage ports with model expectations, per test lines and counts
`default_nettype none

module mem_stage_checker (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  mem_op_pkg::mem_op_e    op_i,
  input  mem_bus_pkg::mem_req_t  mem_req_i,
  input  logic                   stall_i,
  input  mem_op_pkg::exc_code_e  exc_code_i,
  input  mem_bus_pkg::wb_t       wb_i,
  input  mem_bus_pkg::mem_req_t  exp_req_i,
  input  logic                   exp_stall_i,
  input  mem_op_pkg::exc_code_e  exp_code_i,
  input  mem_bus_pkg::wb_t       exp_wb_i,
  output int                     mismatch_cnt_o
);

  import mem_op_pkg::*;

  int       mismatch_cnt = 0;
  int       tests = 0;
  int       failed = 0;
  int       cur_errs = 0;
  int       pend_errs = 0;
  logic     pending = 1'b0;
  mem_op_e  pend_op;

  assign mismatch_cnt_o = mismatch_cnt;

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want,
                         inout int errs);
    if (got !== want)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
      mismatch_cnt++;
      errs++;
    end
  endtask

  task automatic print_counts();
    $display("tests %0d, failed %0d, mismatches %0d", tests, failed, mismatch_cnt);
  endtask

  // outputs are stable from the falling edge up to here
  always @(posedge clk)
  begin
    int wb_errs;
    wb_errs = 0;
    if (rst_n_i)
    begin
      compare("mem_req_o.ce", 32'(mem_req_i.ce), 32'(exp_req_i.ce), cur_errs);
      compare("mem_req_o.we", 32'(mem_req_i.we), 32'(exp_req_i.we), cur_errs);
      if (exp_req_i.ce)
      begin
        compare("mem_req_o.sel", 32'(mem_req_i.sel), 32'(exp_req_i.sel), cur_errs);
        compare("mem_req_o.addr", mem_req_i.addr, exp_req_i.addr, cur_errs);
        if (exp_req_i.we)
        begin
          compare("mem_req_o.wdata", mem_req_i.wdata, exp_req_i.wdata, cur_errs);
        end
      end
      compare("stall_o", 32'(stall_i), 32'(exp_stall_i), cur_errs);
      compare("exc_code_o", 32'(exc_code_i), 32'(exp_code_i), cur_errs);
      // writeback of the instruction retired one edge ago
      compare("wb_o.wreg", 32'(wb_i.wreg), 32'(exp_wb_i.wreg), wb_errs);
      if (exp_wb_i.wreg)
      begin
        compare("wb_o.wd", 32'(wb_i.wd), 32'(exp_wb_i.wd), wb_errs);
        compare("wb_o.wdata", wb_i.wdata, exp_wb_i.wdata, wb_errs);
      end
      if (pending)
      begin
        tests++;
        if (pend_errs + wb_errs == 0)
        begin
          $display("test %0d %s: pass", tests, pend_op.name());
        end
        else
        begin
          failed++;
          $display("test %0d %s: failed, %0d mismatches", tests, pend_op.name(),
                   pend_errs + wb_errs);
        end
        pending = 1'b0;
      end
      if (!exp_stall_i)
      begin
        pending   = (op_i != MEM_NOP) || (exp_code_i != EXC_NONE);
        pend_op   = op_i;
        pend_errs = cur_errs;
        cur_errs  = 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_mem_stage.sv
// testbench with clock, reset, seeded random stimulus, memory responder and reference model
`default_nettype none

module tb_mem_stage;

  import mem_op_pkg::*;
  import mem_bus_pkg::*;

  logic         clk;
  logic         rst_n_i;
  ex_mem_t      ex_i;
  exc_flags_t   exc_i;
  logic [31:0]  mem_rdata_i;
  logic         mem_rdata_valid_i;
  logic         mem_wresp_valid_i;
  mem_req_t     mem_req_o;
  logic         stall_o;
  exc_code_e    exc_code_o;
  wb_t          wb_o;
  mem_req_t     exp_req;
  logic         exp_stall;
  exc_code_e    exp_code;
  wb_t          exp_wb;
  logic         model_ll;
  logic         timed_out;
  int           mismatches;

  mem_stage_top i_dut (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .ex_i              (ex_i),
    .exc_i             (exc_i),
    .mem_rdata_i       (mem_rdata_i),
    .mem_rdata_valid_i (mem_rdata_valid_i),
    .mem_wresp_valid_i (mem_wresp_valid_i),
    .mem_req_o         (mem_req_o),
    .stall_o           (stall_o),
    .exc_code_o        (exc_code_o),
    .wb_o              (wb_o)
  );

  mem_stage_checker i_checker (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .op_i           (ex_i.op),
    .mem_req_i      (mem_req_o),
    .stall_i        (stall_o),
    .exc_code_i     (exc_code_o),
    .wb_i           (wb_o),
    .exp_req_i      (exp_req),
    .exp_stall_i    (exp_stall),
    .exp_code_i     (exp_code),
    .exp_wb_i       (exp_wb),
    .mismatch_cnt_o (mismatches)
  );

  // expected request, lanes big-endian
  function automatic mem_req_t model_req(ex_mem_t ex, exc_flags_t f, logic ll);
    mem_req_t    r;
    logic [1:0]  off;
    r   = '0;
    off = ex.addr[1:0];
    case (ex.op)
      MEM_LB, MEM_LBU, MEM_SB: r.sel = 4'b1000 >> off;
      MEM_LH, MEM_LHU, MEM_SH: r.sel = off[0] ? 4'b0000 : (off[1] ? 4'b0011 : 4'b1100);
      MEM_LW, MEM_LL, MEM_SW:  r.sel = 4'b1111;
      MEM_SC:                  r.sel = ll ? 4'b1111 : 4'b0000;
      default:                 r.sel = 4'b0000;
    endcase
    r.ce    = (ex.op != MEM_NOP) && (ex.op != MEM_SC || ll) && (f == '0);
    r.we    = r.ce && (ex.op == MEM_SB || ex.op == MEM_SH || ex.op == MEM_SW ||
                       ex.op == MEM_SC);
    r.addr  = ex.addr;
    r.wdata = (ex.op == MEM_SB) ? {4{ex.store_data[7:0]}} :
              (ex.op == MEM_SH) ? {2{ex.store_data[15:0]}} : ex.store_data;
    return r;
  endfunction

  function automatic exc_code_e model_code(exc_flags_t f);
    if (f.syscall) return EXC_SYSCALL;
    if (f.inst_invalid) return EXC_RI;
    if (f.trap) return EXC_TRAP;
    if (f.overflow) return EXC_OV;
    if (f.eret) return EXC_ERET;
    return EXC_NONE;
  endfunction

  function automatic logic [31:0] model_wdata(ex_mem_t ex, logic [31:0] rd, logic sc_ok);
    logic [7:0]   b;
    logic [15:0]  h;
    case (ex.addr[1:0])
      2'd0:    b = rd[31:24];
      2'd1:    b = rd[23:16];
      2'd2:    b = rd[15:8];
      default: b = rd[7:0];
    endcase
    h = ex.addr[1] ? rd[15:0] : rd[31:16];
    case (ex.op)
      MEM_LB:         return {{24{b[7]}}, b};
      MEM_LBU:        return {24'h0, b};
      MEM_LH:         return ex.addr[0] ? 32'h0 : {{16{h[15]}}, h};
      MEM_LHU:        return ex.addr[0] ? 32'h0 : {16'h0, h};
      MEM_LW, MEM_LL: return rd;
      MEM_SC:         return {31'h0, sc_ok};
      default:        return ex.alu_result;
    endcase
  endfunction

  function automatic ex_mem_t make_instr(mem_op_e op, logic wreg_always);
    ex_mem_t ex;
    ex.op         = op;
    ex.addr       = $urandom;
    ex.store_data = $urandom;
    ex.wd         = 5'($urandom);
    ex.wreg       = wreg_always || ($urandom_range(3, 0) != 0);
    ex.alu_result = $urandom;
    return ex;
  endfunction

  function automatic exc_flags_t make_flags();
    return ($urandom_range(7, 0) == 0) ? exc_flags_t'(5'($urandom)) : exc_flags_t'(5'h0);
  endfunction

  always_comb
  begin
    exp_req   = model_req(ex_i, exc_i, model_ll);
    exp_code  = model_code(exc_i);
    exp_stall = exp_req.ce && (exp_req.we ? !mem_wresp_valid_i : !mem_rdata_valid_i);
  end

  always @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      model_ll <= 1'b0;
      exp_wb   <= '0;
    end
    else
    begin
      exp_wb.wreg  <= ex_i.wreg && (exp_code == EXC_NONE) && !exp_stall;
      exp_wb.wd    <= ex_i.wd;
      exp_wb.wdata <= model_wdata(ex_i, mem_rdata_i, model_ll && (exp_code == EXC_NONE));
      if (!exp_stall && exp_code != EXC_NONE)
        model_ll <= 1'b0;
      else if (!exp_stall && ex_i.op == MEM_LL)
        model_ll <= 1'b1;
      else if (!exp_stall && ex_i.op == MEM_SC)
        model_ll <= 1'b0;
    end
  end

  // drive one instruction, answer as the memory, wait for it to retire
  task automatic run_instr(input ex_mem_t ex, input exc_flags_t f);
    mem_req_t  req;
    int        cycles;
    ex_i              = ex;
    exc_i             = f;
    mem_rdata_i       = $urandom;
    mem_rdata_valid_i = 1'b0;
    mem_wresp_valid_i = 1'b0;
    req = model_req(ex, f, model_ll);
    if (req.ce)
    begin
      repeat ($urandom_range(3, 0)) @(negedge clk);
      if (req.we)
        mem_wresp_valid_i = 1'b1;
      else
        mem_rdata_valid_i = 1'b1;
    end
    cycles = 0;
    @(posedge clk);
    while (stall_o && cycles < 8)
    begin
      cycles++;
      @(posedge clk);
    end
    if (stall_o)
    begin
      $display("timeout: stall_o stayed high after the memory answered a %s", ex.op.name());
      timed_out = 1'b1;
    end
    @(negedge clk);
    mem_rdata_valid_i = 1'b0;
    mem_wresp_valid_i = 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    int unsigned  seed;
    seed = 32'haeb5_8710;
    void'($urandom(seed));
    timed_out         = 1'b0;
    rst_n_i           = 1'b0;
    ex_i              = '0;
    exc_i             = '0;
    mem_rdata_i       = '0;
    mem_rdata_valid_i = 1'b0;
    mem_wresp_valid_i = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    // LL/SC pairs, then an exception between LL and SC
    run_instr(make_instr(MEM_LL, 1'b1), '0);
    run_instr(make_instr(MEM_SC, 1'b1), '0);
    run_instr(make_instr(MEM_SC, 1'b1), '0);
    run_instr(make_instr(MEM_LL, 1'b1), '0);
    run_instr(make_instr(MEM_LW, 1'b1), exc_flags_t'(5'b00101));
    run_instr(make_instr(MEM_SC, 1'b1), '0);
    for (int i = 0; i < 200 && !timed_out; i++)
    begin
      run_instr(make_instr(mem_op_e'(4'($urandom_range(10, 0))), 1'b0), make_flags());
    end
    ex_i  = '0;
    exc_i = '0;
    repeat (2) @(posedge clk);
    // let the checker finish its last edge
    @(negedge clk);
    i_checker.print_counts();
    if (timed_out || mismatches != 0)
    begin
      $display("RESULT: FAIL");
    end
    else
    begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/mem_op_pkg.sv
design/mem_bus_pkg.sv
design/except_resolve.sv
design/lsu_request.sv
design/load_formatter.sv
design/mem_wb_reg.sv
design/mem_stage_top.sv
test/mem_stage_checker.sv
test/tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - design
    files:
      - design/mem_op_pkg.sv
      - design/mem_bus_pkg.sv
      - design/except_resolve.sv
      - design/lsu_request.sv
      - design/load_formatter.sv
      - design/mem_wb_reg.sv
      - design/mem_stage_top.sv
  - target: test
    files:
      - test/mem_stage_checker.sv
      - test/tb_mem_stage.sv
